// ==== sources.f ====
+incdir+src
src/pat_pkg.sv
src/pat_alu.sv
src/pat_decode.sv
src/pat_program_counter.sv
src/pat_data_mem.sv
src/pat_execute.sv
src/pat_top.sv
verif/pat_assert.sv
verif/pat_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = pat_tb
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	@out="$$(./$(BUILD)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(BUILD)

// ==== verif/pat_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_params.svh"

module pat_tb import pat_pkg::* ; ( ) ;

	localparam cond_t  COND_AL = `PAT_COND_ALWAYS ;
	localparam cond_t  COND_Z  = `PAT_COND_ZERO ;
	localparam cond_t  COND_N  = `PAT_COND_NEG ;
	localparam instr_t NOP_WORD = {5'd0, `PAT_COND_ALWAYS, 1'b0,
		`PAT_PREFIX, `PAT_PREFIX, `PAT_OP0_NOP} ;

	logic        clk = 1'b0 ;
	logic        reset = 1'b1 ;
	instr_t      instr = NOP_WORD ;
	pc_t         pc ;
	data_t       acc ;
	out_write_t  dut_out ;

	instr_t      prog [1024] ;
	int          plen ;
	data_t       m_mem [256] ;  // model data memory
	data_t       m_acc ;
	logic        m_z ;
	logic        m_n ;
	logic [10:0] exp_q [$] ;    // {idx, data} per expected strobe
	logic [15:0] lfsr = 16'd45606 ;

	always #5 clk = ~clk ;

	// instruction memory, answers the pc seen before the edge
	always @(posedge clk)
		instr <= prog[pc] ;

	pat_top u_pat_top (
		.clk     (clk),
		.reset   (reset),
		.i_instr (instr),
		.o_pc    (pc),
		.o_acc   (acc),
		.o_out   (dut_out)
	) ;

	// ==================================================
	// stimulus helpers
	function automatic logic [7:0] rand_bits(input int n) ;
		logic [7:0] v ;
		int         k ;
		v = '0 ;
		for (k = 0 ; k < n ; k++)
		begin
			v = {v[6:0], lfsr[0]} ;
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1) ;
		end
		return v ;
	endfunction

	function automatic instr_t enc8(input cond_t c, input opcode_t op, input data_t imm) ;
		return {5'd0, c, 1'b0, op, imm} ;
	endfunction

	function automatic instr_t enc3(input cond_t c, input opcode_t op, input logic [2:0] imm) ;
		return {5'd0, c, 1'b0, `PAT_PREFIX, op, 1'b0, imm} ;
	endfunction

	function automatic instr_t enc0(input cond_t c, input opcode_t op) ;
		return {5'd0, c, 1'b0, `PAT_PREFIX, `PAT_PREFIX, op} ;
	endfunction

	task automatic new_prog() ;
		int a ;
		for (a = 0 ; a < 1024 ; a++)
			prog[a] = NOP_WORD ;
		plen = 0 ;
	endtask

	task automatic put(input instr_t w) ;
		prog[plen] = w ;
		plen++ ;
	endtask

	task automatic op_out(input instr_t w, input int idx) ;
		put(w) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'(idx))) ;
	endtask

	// ==================================================
	// reference model
	function automatic data_t asr8(input data_t a, input logic [2:0] sh) ;
		data_t v ;
		int    k ;
		v = a >> sh ;
		for (k = 0 ; k < int'(sh) ; k++)
			v[7-k] = a[7] ;  // copy the sign into vacated bits
		return v ;
	endfunction

	task automatic run_model() ;
		int     mpc ;
		int     next ;
		int     tgt ;
		int     pend ;
		int     steps ;
		instr_t w ;
		cond_t  c ;
		data_t  imm ;
		data_t  b ;
		data_t  r ;
		logic   ok ;
		logic   wr ;
		m_acc = '0 ;
		m_z = 1'b0 ;
		m_n = 1'b0 ;
		exp_q.delete() ;
		mpc = 0 ;
		pend = 0 ;
		tgt = 0 ;
		steps = 0 ;
		while (mpc < plen && steps < 400)
		begin
			w = prog[mpc] ;
			c = w[14:13] ;
			imm = w[7:0] ;
			b = imm ;
			ok = (c == `PAT_COND_ZERO) ? m_z : ((c == `PAT_COND_NEG) ? m_n : 1'b1) ;
			wr = 1'b1 ;
			r = m_acc ;
			if (w[11:8] inside {`PAT_OP8_ADDM, `PAT_OP8_SUBM, `PAT_OP8_LDM,
				`PAT_OP8_ORM, `PAT_OP8_ANDM})
				b = m_mem[imm] ;
			if (w[11:8] != `PAT_PREFIX)
			begin
				case (w[11:8])
					`PAT_OP8_OR, `PAT_OP8_ORM:   r = m_acc | b ;
					`PAT_OP8_AND, `PAT_OP8_ANDM: r = m_acc & b ;
					`PAT_OP8_ADD, `PAT_OP8_ADDM: r = m_acc + b ;
					`PAT_OP8_SUB, `PAT_OP8_SUBM: r = m_acc - b ;
					`PAT_OP8_LDI, `PAT_OP8_LDM:  r = b ;
					default:                     wr = 1'b0 ;
				endcase
				if (ok && w[11:8] == `PAT_OP8_STAM)
					m_mem[imm] = m_acc ;
			end
			else if (w[7:4] != `PAT_PREFIX)
			begin
				case (w[7:4])
					`PAT_OP3_SHL: r = m_acc << w[2:0] ;
					`PAT_OP3_SHR: r = m_acc >> w[2:0] ;
					`PAT_OP3_ASR: r = asr8(m_acc, w[2:0]) ;
					default:      wr = 1'b0 ;
				endcase
				if (ok && w[7:4] == `PAT_OP3_OUT)
					exp_q.push_back({w[2:0], m_acc}) ;
			end
			else if (w[3:0] == `PAT_OP0_NOT)
				r = ~m_acc ;
			else
				wr = 1'b0 ;
			if (ok && wr)
			begin
				m_acc = r ;
				m_z = (r == '0) ;
				m_n = r[7] ;
			end
			// two delay slots, then the target
			next = (pend == 1) ? tgt : mpc + 1 ;
			if (pend > 0)
				pend-- ;
			if (w[11:8] == `PAT_OP8_BF || w[11:8] == `PAT_OP8_BB)
			begin
				tgt = (w[11:8] == `PAT_OP8_BF) ? (mpc + 2 + int'(imm)) % 1024
					: (mpc + 2 - int'(imm) + 1024) % 1024 ;
				pend = 2 ;
			end
			mpc = next ;
			steps++ ;
		end
	endtask

	// ==================================================
	// checking and sequencing
	task automatic fail_run(input string why) ;
		$display("%s", why) ;
		$display("Verification failed") ;
		$fatal(1) ;
	endtask

	task automatic check(input string name, input logic [10:0] expv, input logic [10:0] actv) ;
		if (expv !== actv)
			fail_run($sformatf("error: %s expected 0x%0h actual 0x%0h", name, expv, actv)) ;
	endtask

	task automatic pulse_reset() ;
		@(posedge clk) ;
		reset <= 1'b1 ;
		repeat (2) @(posedge clk) ;
		reset <= 1'b0 ;
		@(negedge clk) ;
	endtask

	task automatic wait_out(input string name, output logic [10:0] got) ;
		int t ;
		t = 0 ;
		@(negedge clk) ;
		while (!dut_out.valid)
		begin
			if (t == 100)
				fail_run($sformatf("timeout: no out strobe within 100 cycles in %s", name)) ;
			@(negedge clk) ;
			t++ ;
		end
		got = {dut_out.idx, dut_out.data} ;
	endtask

	task automatic expect_strobes(input string name, input int count) ;
		logic [10:0] got ;
		int          k ;
		for (k = 0 ; k < count ; k++)
		begin
			wait_out(name, got) ;
			check(name, exp_q[k], got) ;
		end
	endtask

	task automatic run_test(input string name) ;
		run_model() ;
		pulse_reset() ;
		expect_strobes(name, exp_q.size()) ;
	endtask

	// ==================================================
	// directed tests
	task automatic test_ldi_out() ;
		int i ;
		new_prog() ;
		for (i = 0 ; i < 8 ; i++)
			op_out(enc8(COND_AL, `PAT_OP8_LDI, rand_bits(8)), i) ;
		run_test("ldi_out") ;
	endtask

	task automatic test_alu_chain() ;
		int i ;
		new_prog() ;
		put(enc8(COND_AL, `PAT_OP8_LDI, rand_bits(8))) ;
		for (i = 0 ; i < 4 ; i++)
		begin
			op_out(enc8(COND_AL, `PAT_OP8_ADD, rand_bits(8)), 0) ;
			op_out(enc8(COND_AL, `PAT_OP8_SUB, rand_bits(8)), 1) ;
			op_out(enc8(COND_AL, `PAT_OP8_OR, rand_bits(8)), 2) ;
			op_out(enc8(COND_AL, `PAT_OP8_AND, rand_bits(8)), 3) ;
			op_out(enc0(COND_AL, `PAT_OP0_NOT), 4) ;
			op_out(enc3(COND_AL, `PAT_OP3_SHL, 3'(rand_bits(3))), 5) ;
			op_out(enc3(COND_AL, `PAT_OP3_SHR, 3'(rand_bits(3))), 6) ;
			put(enc8(COND_AL, `PAT_OP8_LDI, 8'h80 | rand_bits(7))) ;  // negative for asr
			op_out(enc3(COND_AL, `PAT_OP3_ASR, 3'(rand_bits(3))), 7) ;
		end
		run_test("alu_chain") ;
	endtask

	task automatic test_memory() ;
		int i ;
		new_prog() ;
		for (i = 0 ; i < 4 ; i++)
		begin
			put(enc8(COND_AL, `PAT_OP8_LDI, rand_bits(8))) ;
			put(enc8(COND_AL, `PAT_OP8_STAM, 8'h40 + 8'(i))) ;
		end
		put(NOP_WORD) ;  // last store lands before the first load reads
		op_out(enc8(COND_AL, `PAT_OP8_LDM, 8'h40), 0) ;
		op_out(enc8(COND_AL, `PAT_OP8_ADDM, 8'h41), 1) ;
		op_out(enc8(COND_AL, `PAT_OP8_SUBM, 8'h42), 2) ;
		op_out(enc8(COND_AL, `PAT_OP8_ORM, 8'h43), 3) ;
		op_out(enc8(COND_AL, `PAT_OP8_ANDM, 8'h41), 4) ;
		run_test("memory") ;
	endtask

	task automatic test_conditional() ;
		new_prog() ;
		put(enc8(COND_AL, `PAT_OP8_LDI, 8'h00)) ;  // z set
		put(enc3(COND_Z, `PAT_OP3_OUT, 3'd1)) ;
		put(enc3(COND_N, `PAT_OP3_OUT, 3'd2)) ;
		put(enc8(COND_N, `PAT_OP8_LDI, 8'h55)) ;
		put(enc3(2'b10, `PAT_OP3_OUT, 3'd3)) ;     // 10 acts as always
		put(enc8(COND_AL, `PAT_OP8_LDI, 8'h90)) ;  // n set
		put(enc3(COND_Z, `PAT_OP3_OUT, 3'd4)) ;
		put(enc3(COND_N, `PAT_OP3_OUT, 3'd5)) ;
		put(enc8(COND_Z, `PAT_OP8_LDI, 8'h11)) ;
		put(enc8(COND_N, `PAT_OP8_SUB, 8'h10)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd6)) ;
		put(enc8(COND_AL, `PAT_OP8_SUB, 8'h80)) ;  // result zero
		put(enc8(COND_Z, `PAT_OP8_LDI, rand_bits(8) | 8'h01)) ;
		put(enc3(COND_Z, `PAT_OP3_OUT, 3'd7)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd0)) ;
		run_test("conditional") ;
	endtask

	task automatic test_branches() ;
		new_prog() ;
		put(enc8(COND_AL, `PAT_OP8_LDI, rand_bits(8))) ;
		put(enc8(COND_AL, `PAT_OP8_BF, 8'd5)) ;   // 1 -> 8
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd1)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd2)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd7)) ;  // block reached only from the bb
		put(enc8(COND_AL, `PAT_OP8_BF, 8'd4)) ;   // 5 -> 11
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd3)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd4)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd5)) ;
		put(enc8(COND_AL, `PAT_OP8_BB, 8'd7)) ;   // 9 -> 4
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd6)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd0)) ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd1)) ;
		run_test("branches") ;
	endtask

	task automatic test_reset_mid() ;
		int i ;
		new_prog() ;
		put(enc3(COND_AL, `PAT_OP3_OUT, 3'd0)) ;  // acc still zero here
		for (i = 1 ; i < 7 ; i++)
			op_out(enc8(COND_AL, `PAT_OP8_LDI, rand_bits(8)), i) ;
		run_model() ;
		pulse_reset() ;
		expect_strobes("reset_mid", 3) ;
		pulse_reset() ;
		check("reset_mid", 11'd0, {3'd0, acc}) ;
		expect_strobes("reset_mid", exp_q.size()) ;
	endtask

	initial
	begin
		new_prog() ;
		test_ldi_out() ;
		test_alu_chain() ;
		test_memory() ;
		test_conditional() ;
		test_branches() ;
		test_reset_mid() ;
		$display("Verification passed") ;
		$finish ;
	end

endmodule

`default_nettype wire

// ==== verif/pat_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_assert import pat_pkg::* ; (
	input logic       clk,
	input logic       reset,
	input pc_t        i_pc,
	input data_t      i_acc,
	input out_write_t i_out
) ;

	// ==================================================
	// top-level port checks
	valid_known : assert property (@(posedge clk) disable iff (reset) !$isunknown(i_out.valid))
		else $error("out strobe is unknown") ;

	// first edge after release
	reset_state : assert property (@(posedge clk) $fell(reset) |-> (i_pc == '0) && !i_out.valid)
		else $error("pc or out strobe not cleared by reset") ;

	acc_known : assert property (@(posedge clk) disable iff (reset) !$isunknown(i_acc))
		else $error("accumulator is unknown after reset") ;

endmodule

bind pat_top pat_assert u_pat_assert (
	.clk   (clk),
	.reset (reset),
	.i_pc  (o_pc),
	.i_acc (o_acc),
	.i_out (o_out)
) ;

`default_nettype wire

// ==== src/pat_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_top import pat_pkg::* ; (
	input  logic       clk,
	input  logic       reset,
	input  instr_t     i_instr,
	output pc_t        o_pc,
	output data_t      o_acc,
	output out_write_t o_out
) ;

	branch_t     branch ;
	dmem_adr_t   dmem_rd_adr ;
	data_t       dmem_rd_data ;
	decoded_t    decoded ;
	dmem_write_t dmem_write ;

	// ==================================================
	// stage 1, fetch register and decode
	pat_decode u_decode (
		.clk            (clk),
		.reset          (reset),
		.i_instr        (i_instr),
		.i_dmem_rd_data (dmem_rd_data),
		.o_dmem_rd_adr  (dmem_rd_adr),
		.o_branch       (branch),
		.o_decoded      (decoded)
	) ;

	pat_program_counter u_pc (
		.clk      (clk),
		.reset    (reset),
		.i_branch (branch),
		.o_pc     (o_pc)
	) ;

	pat_data_mem u_dmem (
		.clk       (clk),
		.i_rd_adr  (dmem_rd_adr),
		.o_rd_data (dmem_rd_data),
		.i_write   (dmem_write)
	) ;

	// ==================================================
	// stage 2, commit
	pat_execute u_execute (
		.clk          (clk),
		.reset        (reset),
		.i_decoded    (decoded),
		.o_dmem_write (dmem_write),
		.o_out        (o_out),
		.o_acc        (o_acc)
	) ;

endmodule

`default_nettype wire

// ==== src/pat_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_params.svh"

module pat_execute import pat_pkg::* ; (
	input  logic        clk,
	input  logic        reset,
	input  decoded_t    i_decoded,
	output dmem_write_t o_dmem_write,
	output out_write_t  o_out,
	output data_t       o_acc
) ;

	data_t      acc ;
	logic       z ;
	logic       n ;
	logic       commit ;
	data_t      alu_y ;
	out_write_t out_q ;

	function automatic logic cond_met(input cond_t c, input logic zf, input logic nf) ;
		case (c)
			`PAT_COND_ZERO: cond_met = zf ;
			`PAT_COND_NEG:  cond_met = nf ;
			default:        cond_met = 1'b1 ;  // always
		endcase
	endfunction

	pat_alu u_alu (
		.i_a  (acc),
		.i_b  (i_decoded.b),
		.i_op (i_decoded.alu_op),
		.o_y  (alu_y)
	) ;

	assign commit = cond_met(i_decoded.cond, z, n) ;

	// ==================================================
	// accumulator and flags
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			acc <= '0 ;
			z <= 1'b0 ;
			n <= 1'b0 ;
		end
		else if (commit && i_decoded.write_acc)
		begin
			acc <= alu_y ;
			z <= (alu_y == '0) ;
			n <= alu_y[`PAT_D_WIDTH-1] ;
		end
	end

	// store lands on this same edge
	assign o_dmem_write.en   = commit && i_decoded.write_mem ;
	assign o_dmem_write.adr  = dmem_adr_t'(i_decoded.imm) ;
	assign o_dmem_write.data = acc ;

	// out strobe, one cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			out_q.valid <= 1'b0 ;
		else
			out_q.valid <= commit && i_decoded.write_out ;
		if (commit && i_decoded.write_out)
		begin
			out_q.idx  <= i_decoded.imm[`PAT_OUT_PORT_BITS-1:0] ;
			out_q.data <= acc ;
		end
	end

	assign o_out = out_q ;
	assign o_acc = acc ;

endmodule

`default_nettype wire

// ==== src/pat_data_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_params.svh"

module pat_data_mem import pat_pkg::* ; (
	input  logic        clk,
	input  dmem_adr_t   i_rd_adr,
	output data_t       o_rd_data,
	input  dmem_write_t i_write
) ;

	data_t mem [`PAT_DMEM_DEPTH] ;

	// read is combinational, decode samples it at its edge
	assign o_rd_data = mem[i_rd_adr] ;

	always_ff @(posedge clk)
	begin
		if (i_write.en)
			mem[i_write.adr] <= i_write.data ;
	end

endmodule

`default_nettype wire

// ==== src/pat_program_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_program_counter import pat_pkg::* ; (
	input  logic    clk,
	input  logic    reset,
	input  branch_t i_branch,
	output pc_t     o_pc
) ;

	pc_t pc ;
	pc_t offset ;

	// offset is unsigned, direction comes from the opcode
	assign offset = pc_t'(i_branch.offset) ;

	// pc already points two past the branch when it is decoded
	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0 ;
		else if (i_branch.fwd)
			pc <= pc + offset ;
		else if (i_branch.bwd)
			pc <= pc - offset ;  // wraps mod 1024
		else
			pc <= pc + pc_t'(1) ;
	end

	assign o_pc = pc ;

endmodule

`default_nettype wire

// ==== src/pat_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pat_params.svh"

module pat_decode import pat_pkg::* ; (
	input  logic      clk,
	input  logic      reset,
	input  instr_t    i_instr,
	input  data_t     i_dmem_rd_data,
	output dmem_adr_t o_dmem_rd_adr,
	output branch_t   o_branch,
	output decoded_t  o_decoded
) ;

	localparam instr_t NOP_WORD = {5'd0, `PAT_COND_ALWAYS, 1'b0,
		`PAT_PREFIX, `PAT_PREFIX, `PAT_OP0_NOP} ;
	localparam decoded_t NOP_DECODED = '{cond: `PAT_COND_ALWAYS, alu_op: ALU_PASS_B,
		b: '0, imm: '0, write_acc: 1'b0, write_mem: 1'b0, write_out: 1'b0} ;

	instr_t     ir ;
	logic       fetch_live ;  // low on the first edge out of reset
	cond_t      cond ;
	opcode_t    op8 ;
	opcode_t    op3 ;
	opcode_t    op0 ;
	data_t      imm8 ;
	logic [2:0] imm3 ;
	logic       is_i8 ;
	logic       is_i3 ;
	logic       is_i0 ;
	logic       use_mem ;
	logic       acc_op ;
	alu_op_e    alu_op ;
	data_t      operand_b ;
	decoded_t   dec_q ;

	// ==================================================
	// instruction register
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ir <= NOP_WORD ;
			fetch_live <= 1'b0 ;
		end
		else
		begin
			ir <= fetch_live ? i_instr : NOP_WORD ;  // word fetched under reset is stale
			fetch_live <= 1'b1 ;
		end
	end

	// bits 19:15 and the old field_op bit are ignored
	assign cond = ir[14:13] ;
	assign op8  = ir[11:8] ;
	assign imm8 = ir[7:0] ;
	assign op3  = ir[7:4] ;
	assign imm3 = ir[2:0] ;
	assign op0  = ir[3:0] ;

	assign is_i8 = (op8 != `PAT_PREFIX) ;
	assign is_i3 = (op8 == `PAT_PREFIX) && (op3 != `PAT_PREFIX) ;
	assign is_i0 = (op8 == `PAT_PREFIX) && (op3 == `PAT_PREFIX) ;

	// ==================================================
	// opcode decode, anything unlisted is a nop
	always_comb
	begin
		alu_op = ALU_PASS_B ;
		acc_op = 1'b1 ;
		if (is_i8)
		begin
			case (op8)
				`PAT_OP8_OR, `PAT_OP8_ORM:   alu_op = ALU_OR ;
				`PAT_OP8_AND, `PAT_OP8_ANDM: alu_op = ALU_AND ;
				`PAT_OP8_ADD, `PAT_OP8_ADDM: alu_op = ALU_ADD ;
				`PAT_OP8_SUB, `PAT_OP8_SUBM: alu_op = ALU_SUB ;
				`PAT_OP8_LDI, `PAT_OP8_LDM:  alu_op = ALU_PASS_B ;
				default:                     acc_op = 1'b0 ;  // branches, stam
			endcase
		end
		else if (is_i3)
		begin
			case (op3)
				`PAT_OP3_SHL: alu_op = ALU_SHL ;
				`PAT_OP3_SHR: alu_op = ALU_SHR ;
				`PAT_OP3_ASR: alu_op = ALU_ASR ;
				default:      acc_op = 1'b0 ;
			endcase
		end
		else if (is_i0 && (op0 == `PAT_OP0_NOT))
			alu_op = ALU_NOT ;
		else
			acc_op = 1'b0 ;
	end

	assign use_mem = is_i8 && ((op8 == `PAT_OP8_LDM) || (op8 == `PAT_OP8_ADDM) ||
		(op8 == `PAT_OP8_SUBM) || (op8 == `PAT_OP8_ORM) || (op8 == `PAT_OP8_ANDM)) ;

	assign o_dmem_rd_adr = dmem_adr_t'(imm8) ;
	assign operand_b = use_mem ? i_dmem_rd_data : (is_i8 ? imm8 : data_t'(imm3)) ;

	// branches act on the PC here, unconditionally
	assign o_branch.fwd    = is_i8 && (op8 == `PAT_OP8_BF) ;
	assign o_branch.bwd    = is_i8 && (op8 == `PAT_OP8_BB) ;
	assign o_branch.offset = imm8 ;

	always_ff @(posedge clk)
	begin
		if (reset)
			dec_q <= NOP_DECODED ;
		else
			dec_q <= '{cond: cond, alu_op: alu_op, b: operand_b, imm: imm8,
				write_acc: acc_op,
				write_mem: is_i8 && (op8 == `PAT_OP8_STAM),
				write_out: is_i3 && (op3 == `PAT_OP3_OUT)} ;
	end

	assign o_decoded = dec_q ;

endmodule

`default_nettype wire

// ==== src/pat_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pat_alu import pat_pkg::* ; (
	input  data_t   i_a,
	input  data_t   i_b,
	input  alu_op_e i_op,
	output data_t   o_y
) ;

	logic       is_sub ;
	data_t      b_in ;
	data_t      sum ;
	logic [2:0] sh ;

	// one adder, sub = a + ~b + 1
	assign is_sub = (i_op == ALU_SUB) ;
	assign b_in   = is_sub ? ~i_b : i_b ;
	assign sum    = i_a + b_in + data_t'(is_sub) ;

	assign sh = i_b[2:0] ;  // shift amount

	always_comb
	begin
		case (i_op)
			ALU_OR:     o_y = i_a | i_b ;
			ALU_AND:    o_y = i_a & i_b ;
			ALU_ADD:    o_y = sum ;
			ALU_SUB:    o_y = sum ;
			ALU_NOT:    o_y = ~i_a ;
			ALU_SHL:    o_y = i_a << sh ;
			ALU_SHR:    o_y = i_a >> sh ;
			ALU_ASR:    o_y = data_t'($signed(i_a) >>> sh) ;  // sign fill
			ALU_PASS_B: o_y = i_b ;
			default:    o_y = i_b ;
		endcase
	end

endmodule

`default_nettype wire

// ==== src/pat_pkg.sv ====
`default_nettype none

`include "pat_params.svh"

package pat_pkg ;

	typedef logic [`PAT_I_WIDTH-1:0]       instr_t ;
	typedef logic [`PAT_I_ADR_WIDTH-1:0]   pc_t ;
	typedef logic [`PAT_D_WIDTH-1:0]       data_t ;
	typedef logic [`PAT_D_ADR_WIDTH-1:0]   dmem_adr_t ;
	typedef logic [3:0]                    opcode_t ;
	typedef logic [1:0]                    cond_t ;
	typedef logic [`PAT_OUT_PORT_BITS-1:0] port_idx_t ;

	// accumulator ALU operation, pass_b serves the loads
	typedef enum logic [3:0] {
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_NOT,
		ALU_SHL,
		ALU_SHR,
		ALU_ASR,
		ALU_PASS_B
	} alu_op_e ;

	typedef struct packed {
		logic  fwd ;
		logic  bwd ;
		data_t offset ;
	} branch_t ;

	// decode -> commit
	typedef struct packed {
		cond_t   cond ;
		alu_op_e alu_op ;
		data_t   b ;         // pre-selected operand
		data_t   imm ;       // store address, out index
		logic    write_acc ;
		logic    write_mem ;
		logic    write_out ;
	} decoded_t ;

	typedef struct packed {
		logic      en ;
		dmem_adr_t adr ;
		data_t     data ;
	} dmem_write_t ;

	typedef struct packed {
		logic      valid ;
		port_idx_t idx ;
		data_t     data ;
	} out_write_t ;

endpackage

`default_nettype wire

// ==== src/pat_params.svh ====
`ifndef PAT_PARAMS_SVH
`define PAT_PARAMS_SVH

// widths and depths
`define PAT_I_WIDTH        20
`define PAT_I_ADR_WIDTH    10
`define PAT_D_WIDTH        8
`define PAT_D_ADR_WIDTH    8
`define PAT_DMEM_DEPTH     256
`define PAT_OUT_PORT_BITS  3

// escape code, i8 -> i3 and i3 -> i0
`define PAT_PREFIX         4'b1111

// i8 space
`define PAT_OP8_OR         4'd0
`define PAT_OP8_AND        4'd1
`define PAT_OP8_ADDM       4'd2
`define PAT_OP8_SUBM       4'd3
`define PAT_OP8_ADD        4'd4
`define PAT_OP8_SUB        4'd5
`define PAT_OP8_LDI        4'd6
`define PAT_OP8_LDM        4'd7
`define PAT_OP8_BF         4'd8
`define PAT_OP8_BB         4'd9
`define PAT_OP8_STAM       4'd11
`define PAT_OP8_ORM        4'd13
`define PAT_OP8_ANDM       4'd14

// i3 space
`define PAT_OP3_SHL        4'd0
`define PAT_OP3_SHR        4'd2
`define PAT_OP3_ASR        4'd3
`define PAT_OP3_OUT        4'd8

// i0 space
`define PAT_OP0_NOT        4'd0
`define PAT_OP0_NOP        4'd5

// condition codes, 2'b10 is treated as always too
`define PAT_COND_ZERO      2'b00
`define PAT_COND_NEG       2'b01
`define PAT_COND_ALWAYS    2'b11

`endif
